// ==== tb.f ====
+incdir+verilog
verilog/trig_cfg_pkg.sv
verilog/trig_event_pkg.sv
verilog/trig_cfg_if.sv
verilog/pattern_match.sv
verilog/pw_trigger.sv
verilog/event_arbiter.sv
verilog/trigger_top.sv
test/trigger_asserts.sv
test/trigger_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= trigger_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/trigger_tb.sv ====
`include "trig_settings.svh"

module trigger_tb
   import trig_cfg_pkg::*;
   import trig_event_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   // Run length per test, in cycles, with slack for each trigger run
   localparam int RESET_CYCLES   = 10;
   localparam int DELAY_CYCLES   = 6 * 45;
   localparam int MASK_CYCLES    = 3 * 30 + 35;
   localparam int HOLD_CYCLES    = 45;
   localparam int RECORD_CYCLES  = 45;
   localparam int CREDIT_CYCLES  = 4 * 25 + 40;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + DELAY_CYCLES + MASK_CYCLES + HOLD_CYCLES
                                   + RECORD_CYCLES + CREDIT_CYCLES + 200;
   localparam io_word_t IDLE_BYTE = 8'h00;

   logic                     trigger_clk;
   logic                     reset_i;
   logic                     arm;
   io_word_t                 pattern;
   io_word_t                 mask;
   trig_delay_t              delay;
   trig_width_t              width;
   io_word_t                 io_data;
   logic                     evt_credit;
   logic                     trigger;
   logic                     evt_valid;
   evt_kind_t                evt_kind;
   logic [`TRIG_STAMP_W-1:0] evt_stamp;
   evt_value_t               evt_value;
   logic                     evt_overflow;

   // Test bookkeeping
   string                    test_name;
   io_word_t                 match_byte;
   int                       seed = 32'h422f52c4;
   int                       run_cycles;
   logic [`TRIG_STAMP_W-1:0] cyc;
   // Trigger monitor
   int                       trig_pulses;
   int                       trig_rise_cyc;
   int                       trig_high_cnt;
   logic                     trig_active;
   // Event model
   trig_event_t              exp_q [$];
   trig_event_t              mon_e;
   int                       evt_seen;

   trigger_top i_trigger_top (
      .trigger_clk  (trigger_clk),
      .reset_i      (reset_i),
      .arm          (arm),
      .pattern      (pattern),
      .mask         (mask),
      .delay        (delay),
      .width        (width),
      .io_data      (io_data),
      .evt_credit   (evt_credit),
      .trigger      (trigger),
      .evt_valid    (evt_valid),
      .evt_kind     (evt_kind),
      .evt_stamp    (evt_stamp),
      .evt_value    (evt_value),
      .evt_overflow (evt_overflow)
   );

   initial trigger_clk = 1'b0;
   always #5 trigger_clk = ~trigger_clk;

   // Mirror of the time stamp, zero through reset
   always @(posedge trigger_clk) begin
      if (reset_i) begin
         cyc <= '0;
      end else begin
         cyc <= cyc + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Reporting and compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_trigger(input string what, input int exp, input int act);
      if (exp != act) begin
         fail_run($sformatf("MISMATCH test=%s %s expected=%0d actual=%0d",
                            test_name, what, exp, act));
      end
   endtask

   task automatic check_count(input string what, input int exp, input int act);
      if (exp != act) begin
         fail_run($sformatf("MISMATCH test=%s %s expected=%0d actual=%0d",
                            test_name, what, exp, act));
      end
   endtask

   task automatic check_event(input evt_kind_t exp_kind,
                              input logic [`TRIG_STAMP_W-1:0] exp_stamp,
                              input evt_value_t exp_value);
      if (evt_kind !== exp_kind || evt_stamp !== exp_stamp || evt_value !== exp_value) begin
         fail_run($sformatf("MISMATCH test=%s event expected=%s/%0d/%0d actual=%s/%0d/%0d",
                            test_name, exp_kind.name(), exp_stamp, exp_value,
                            evt_kind.name(), evt_stamp, evt_value));
      end
   endtask

   task automatic check_overflow(input logic exp);
      @(negedge trigger_clk);
      if (evt_overflow !== exp) begin
         fail_run($sformatf("MISMATCH test=%s evt_overflow expected=%0b actual=%0b",
                            test_name, exp, evt_overflow));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Monitors
   //////////////////////////////////////////////////////////////////////

   always @(negedge trigger_clk) begin
      if (reset_i) begin
         trig_active = 1'b0;
      end else begin
         if (trigger && !trig_active) begin
            trig_pulses++;
            trig_rise_cyc = int'(cyc);
            trig_high_cnt = 0;
         end
         if (trigger) begin
            trig_high_cnt++;
         end
         trig_active = trigger;
      end
   end

   // Records compared in arrival order
   always @(negedge trigger_clk) begin
      if (!reset_i && evt_valid) begin
         if (exp_q.size() == 0) begin
            fail_run($sformatf("Test %s: event record arrived with none expected", test_name));
         end else begin
            mon_e = exp_q.pop_front();
            check_event(mon_e.kind, mon_e.stamp, mon_e.value);
            evt_seen++;
         end
      end
   end

   always @(posedge trigger_clk) begin
      run_cycles <= run_cycles + 1;
      if (run_cycles >= TIMEOUT_CYCLES) begin
         fail_run($sformatf("Timeout in test %s after %0d cycles", test_name, run_cycles));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus tasks
   //////////////////////////////////////////////////////////////////////

   task automatic wait_trigger_done(input int base);
      while (trig_pulses <= base || trig_active) begin
         @(posedge trigger_clk);
      end
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0) begin
         @(posedge trigger_clk);
      end
   endtask

   // One matching byte, optional extra matches while busy
   task automatic run_match(input int d, input int w, input int drops,
                            input bit hold, input bit logged);
      int          c;
      int          base;
      int          w_eff;
      trig_event_t exp_e;
      w_eff = (w == 0) ? 1 : w;
      @(posedge trigger_clk);
      delay   <= trig_delay_t'(d);
      width   <= trig_width_t'(w);
      io_data <= IDLE_BYTE;
      @(posedge trigger_clk);
      io_data <= match_byte;
      @(negedge trigger_clk);
      c    = int'(cyc);
      base = trig_pulses;
      if (logged) begin
         exp_e.kind  = EVT_MATCH;
         exp_e.stamp = `TRIG_STAMP_W'(c + 1);
         exp_e.value = evt_value_t'(match_byte);
         exp_q.push_back(exp_e);
      end
      for (int k = 1; k <= drops; k++) begin
         @(posedge trigger_clk);
         io_data <= IDLE_BYTE;
         @(posedge trigger_clk);
         io_data <= match_byte;
         // A match while busy still sends its own match record
         if (logged) begin
            exp_e.kind  = EVT_MATCH;
            exp_e.stamp = `TRIG_STAMP_W'(c + 1 + 2 * k);
            exp_e.value = evt_value_t'(match_byte);
            exp_q.push_back(exp_e);
         end
      end
      if (!hold) begin
         @(posedge trigger_clk);
         io_data <= IDLE_BYTE;
      end
      wait_trigger_done(base);
      if (logged) begin
         exp_e.kind  = EVT_PULSE;
         exp_e.stamp = `TRIG_STAMP_W'(c + 1 + d + 2 + w_eff);
         exp_e.value = evt_value_t'(drops);
         exp_q.push_back(exp_e);
      end
      if (hold) begin
         repeat (10) @(posedge trigger_clk);
         io_data <= IDLE_BYTE;
      end
      check_trigger("trigger delay", d + 2, trig_rise_cyc - c - 1);
      check_trigger("trigger width", w_eff, trig_high_cnt);
      check_trigger("trigger count", 1, trig_pulses - base);
   endtask

   // Byte that must not trigger
   task automatic expect_quiet(input io_word_t b, input int cycles);
      int base_p;
      int base_e;
      base_p = trig_pulses;
      base_e = evt_seen;
      @(posedge trigger_clk);
      io_data <= b;
      repeat (cycles) @(posedge trigger_clk);
      io_data <= IDLE_BYTE;
      repeat (2) @(posedge trigger_clk);
      check_trigger("quiet trigger count", base_p, trig_pulses);
      check_count("quiet event count", base_e, evt_seen);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_delay_width();
      int d;
      int w;
      test_name = "delay_width";
      run_match(0, 1, 0, 0, 1);
      run_match(1, 1, 0, 0, 1);
      run_match(5, 3, 0, 0, 1);
      run_match(12, 7, 0, 0, 1);
      run_match(2, 0, 0, 0, 1);
      d = $unsigned($random(seed)) % 10;
      w = 1 + $unsigned($random(seed)) % 6;
      run_match(d, w, 0, 0, 1);
      wait_drained();
   endtask

   task automatic test_mask_arm();
      test_name = "mask_arm";
      @(posedge trigger_clk);
      mask <= 8'hF0;
      // Low nibble masked off
      match_byte = 8'hA3;
      run_match(2, 2, 0, 0, 1);
      wait_drained();
      expect_quiet(8'hB5, 20);
      @(posedge trigger_clk);
      arm <= 1'b0;
      expect_quiet(8'hA5, 20);
      @(posedge trigger_clk);
      arm        <= 1'b1;
      mask       <= 8'hFF;
      match_byte = 8'hA5;
      expect_quiet(8'hA4, 10);
   endtask

   task automatic test_hold();
      test_name = "hold";
      run_match(1, 2, 0, 1, 1);
      wait_drained();
   endtask

   task automatic test_records();
      test_name = "records";
      // Three extra matches land while busy
      run_match(3, 4, 3, 0, 1);
      wait_drained();
   endtask

   task automatic test_credits();
      int base;
      test_name = "credits";
      check_overflow(1'b0);
      base = evt_seen;
      @(posedge trigger_clk);
      evt_credit <= 1'b0;
      run_match(0, 1, 0, 0, 1);
      run_match(0, 1, 0, 0, 1);
      // Held in the slots
      run_match(0, 1, 0, 0, 1);
      // Slots full, both records lost
      run_match(0, 1, 0, 0, 0);
      repeat (10) @(posedge trigger_clk);
      check_count("records without credit", 4, evt_seen - base);
      check_count("records held", 2, exp_q.size());
      check_overflow(1'b1);
      @(posedge trigger_clk);
      evt_credit <= 1'b1;
      wait_drained();
      check_count("records after credit return", 6, evt_seen - base);
   endtask

   initial begin
      reset_i    = 1'b1;
      arm        = 1'b1;
      pattern    = 8'hA5;
      mask       = 8'hFF;
      delay      = '0;
      width      = trig_width_t'(1);
      io_data    = IDLE_BYTE;
      evt_credit = 1'b1;
      match_byte = 8'hA5;
      test_name  = "reset";
      run_cycles = 0;
      trig_pulses   = 0;
      trig_rise_cyc = 0;
      trig_high_cnt = 0;
      evt_seen      = 0;
      repeat (5) @(posedge trigger_clk);
      reset_i <= 1'b0;
      check_overflow(1'b0);
      test_delay_width();
      test_mask_arm();
      test_hold();
      test_records();
      test_credits();
      repeat (5) @(posedge trigger_clk);
      $display("Testbench passed");
      $finish;
   end

endmodule

// ==== test/trigger_asserts.sv ====
`include "trig_settings.svh"

module trigger_asserts
   import trig_cfg_pkg::*;
(
   input  logic        trigger_clk,
   input  logic        reset_i,
   input  logic        trigger,
   input  logic        pulse_evt,
   input  trig_width_t width_cfg,
   input  logic        evt_sent,
   input  logic        credit_ret
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CREDIT_W = $clog2(`TRIG_EVT_CREDITS + 1);
   localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`TRIG_EVT_CREDITS);

   // High cycles of the current trigger so far
   logic [`TRIG_WIDTH_W:0] run_len;
   // Zero width behaves as one
   logic [`TRIG_WIDTH_W:0] width_eff;
   // Credits left as seen from the port
   // Trails the arbiter counter by one cycle
   logic [CREDIT_W-1:0]    port_credits;
   // Return lined up with the registered evt_valid
   logic                   credit_d;

   assign width_eff = (width_cfg == '0) ? (`TRIG_WIDTH_W + 1)'(1) : {1'b0, width_cfg};

   always_ff @(posedge trigger_clk) begin
      if (reset_i) begin
         run_len <= '0;
      end else if (trigger) begin
         run_len <= run_len + 1'b1;
      end else begin
         run_len <= '0;
      end
   end

   // Spend on each record seen, refund on each returned credit, capped
   always_ff @(posedge trigger_clk) begin
      if (reset_i) begin
         port_credits <= CREDIT_MAX;
         credit_d     <= 1'b0;
      end else begin
         credit_d <= credit_ret;
         if (credit_d && !evt_sent && port_credits != CREDIT_MAX) begin
            port_credits <= port_credits + 1'b1;
         end else if (!credit_d && evt_sent && port_credits != '0) begin
            port_credits <= port_credits - 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Trigger pulse
   //////////////////////////////////////////////////////////////////////

   a_trigger_width : assert property (@(posedge trigger_clk) disable iff (reset_i)
      trigger |-> (run_len < width_eff))
      else $error("trigger stayed high past the programmed width");

   // Trigger ends after exactly the programmed width and brings the pulse event
   a_fall_event : assert property (@(posedge trigger_clk) disable iff (reset_i)
      $fell(trigger) |-> (pulse_evt && run_len == width_eff))
      else $error("trigger fell without a pulse event or after the wrong width");

   //////////////////////////////////////////////////////////////////////
   // Credit use
   //////////////////////////////////////////////////////////////////////

   // Every record on the port had a credit behind it
   a_send_credit : assert property (@(posedge trigger_clk) disable iff (reset_i)
      evt_sent |-> (port_credits != '0))
      else $error("record sent with no credit left");

endmodule

bind pw_trigger trigger_asserts i_pulse_asserts (
   .trigger_clk (trigger_clk),
   .reset_i     (reset_i),
   .trigger     (trigger),
   .pulse_evt   (evt_valid),
   .width_cfg   (cfg.width),
   .evt_sent    (1'b0),
   .credit_ret  (1'b0)
);

bind event_arbiter trigger_asserts i_arbiter_asserts (
   .trigger_clk (trigger_clk),
   .reset_i     (reset_i),
   .trigger     (1'b0),
   .pulse_evt   (1'b0),
   .width_cfg   ('0),
   .evt_sent    (evt_valid),
   .credit_ret  (evt_credit)
);

// ==== verilog/trigger_top.sv ====
`include "trig_settings.svh"

module trigger_top
   import trig_cfg_pkg::*;
   import trig_event_pkg::*;
(
   input  logic                     trigger_clk,
   input  logic                     reset_i,
   input  logic                     arm,
   input  io_word_t                 pattern,
   input  io_word_t                 mask,
   input  trig_delay_t              delay,
   input  trig_width_t              width,
   input  io_word_t                 io_data,
   input  logic                     evt_credit,
   output logic                     trigger,
   output logic                     evt_valid,
   output evt_kind_t                evt_kind,
   output logic [`TRIG_STAMP_W-1:0] evt_stamp,
   output evt_value_t               evt_value,
   output logic                     evt_overflow
);

   // Matcher to trigger generator
   logic        match;
   // Per-source events into the arbiter
   logic        match_evt_valid;
   evt_value_t  match_evt_value;
   logic        pulse_evt_valid;
   evt_value_t  pulse_evt_value;
   trig_event_t evt_data;

   //////////////////////////////////////////////////////////////////////
   // Configuration bundle
   //////////////////////////////////////////////////////////////////////

   trig_cfg_if cfg ();

   assign cfg.arm     = arm;
   assign cfg.pattern = pattern;
   assign cfg.mask    = mask;
   assign cfg.delay   = delay;
   assign cfg.width   = width;

   //////////////////////////////////////////////////////////////////////
   // Event sources
   //////////////////////////////////////////////////////////////////////

   pattern_match i_pattern_match (
      .trigger_clk (trigger_clk),
      .reset_i     (reset_i),
      .cfg         (cfg.match_mp),
      .io_data     (io_data),
      .match       (match),
      .evt_valid   (match_evt_valid),
      .evt_value   (match_evt_value)
   );

   pw_trigger i_pw_trigger (
      .trigger_clk (trigger_clk),
      .reset_i     (reset_i),
      .cfg         (cfg.pulse_mp),
      .match       (match),
      .trigger     (trigger),
      .evt_valid   (pulse_evt_valid),
      .evt_value   (pulse_evt_value)
   );

   // Shared event port
   event_arbiter i_event_arbiter (
      .trigger_clk  (trigger_clk),
      .reset_i      (reset_i),
      .match_valid  (match_evt_valid),
      .match_value  (match_evt_value),
      .pulse_valid  (pulse_evt_valid),
      .pulse_value  (pulse_evt_value),
      .evt_credit   (evt_credit),
      .evt_valid    (evt_valid),
      .evt_data     (evt_data),
      .evt_overflow (evt_overflow)
   );

   // Record fields out as plain ports
   assign evt_kind  = evt_data.kind;
   assign evt_stamp = evt_data.stamp;
   assign evt_value = evt_data.value;

endmodule

// ==== verilog/event_arbiter.sv ====
`include "trig_settings.svh"

module event_arbiter
   import trig_event_pkg::*;
(
   input  logic        trigger_clk,
   input  logic        reset_i,
   input  logic        match_valid,
   input  evt_value_t  match_value,
   input  logic        pulse_valid,
   input  evt_value_t  pulse_value,
   input  logic        evt_credit,
   output logic        evt_valid,
   output trig_event_t evt_data,
   output logic        evt_overflow
);

   localparam int CREDIT_W = $clog2(`TRIG_EVT_CREDITS + 1);
   localparam logic [CREDIT_W:0] CREDIT_MAX = (CREDIT_W + 1)'(`TRIG_EVT_CREDITS);
   // Slot index equals the evt_kind_t encoding
   localparam int SRC_MATCH = 0;
   localparam int SRC_PULSE = 1;

   logic [`TRIG_STAMP_W-1:0] stamp_cnt;
   logic [1:0]               src_valid;
   evt_value_t               src_value [2];
   logic [1:0]               slot_full;
   logic [`TRIG_STAMP_W-1:0] slot_stamp [2];
   evt_value_t               slot_value [2];
   logic [1:0]               capture;
   logic [1:0]               grant;
   logic                     gnt_idx;
   logic                     send;
   // Next turn when both slots wait, 0 is the matcher
   logic                     rr_ptr;
   logic [CREDIT_W-1:0]      credit_cnt;
   logic [CREDIT_W:0]        credit_sum;

   assign src_valid            = {pulse_valid, match_valid};
   assign src_value[SRC_MATCH] = match_value;
   assign src_value[SRC_PULSE] = pulse_value;

   //////////////////////////////////////////////////////////////////////
   // Grant and credits
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      grant = 2'b00;
      // Nothing leaves without a credit
      if (credit_cnt != '0) begin
         if (slot_full == 2'b11) begin
            grant[rr_ptr] = 1'b1;
         end else begin
            grant = slot_full;
         end
      end
   end

   assign send    = |grant;
   assign gnt_idx = grant[SRC_PULSE];

   // Spend on send, refund on evt_credit
   assign credit_sum = {1'b0, credit_cnt} + (CREDIT_W + 1)'(evt_credit)
                       - (CREDIT_W + 1)'(send);

   // A slot being sent this edge can take a new event
   assign capture = src_valid & (~slot_full | grant);

   //////////////////////////////////////////////////////////////////////
   // Control state
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge trigger_clk) begin
      if (reset_i) begin
         stamp_cnt    <= '0;
         slot_full    <= '0;
         rr_ptr       <= 1'b0;
         credit_cnt   <= CREDIT_MAX[CREDIT_W-1:0];
         evt_valid    <= 1'b0;
         evt_overflow <= 1'b0;
      end else begin
         stamp_cnt <= stamp_cnt + 1;
         slot_full <= capture | (slot_full & ~grant);
         evt_valid <= send;
         if (send) begin
            rr_ptr <= ~gnt_idx;
         end
         // Cap at the initial credit count
         credit_cnt <= (credit_sum > CREDIT_MAX) ? CREDIT_MAX[CREDIT_W-1:0]
                                                 : credit_sum[CREDIT_W-1:0];
         // Sticky, cleared only by reset
         if (|(src_valid & ~capture)) begin
            evt_overflow <= 1'b1;
         end
      end
   end

   // Slot payload with arrival stamp
   always_ff @(posedge trigger_clk) begin
      for (int i = 0; i < 2; i++) begin
         if (capture[i]) begin
            slot_stamp[i] <= stamp_cnt;
            slot_value[i] <= src_value[i];
         end
      end
   end

   // Outgoing record
   always_ff @(posedge trigger_clk) begin
      if (send) begin
         evt_data.kind  <= evt_kind_t'(gnt_idx);
         evt_data.stamp <= slot_stamp[gnt_idx];
         evt_data.value <= slot_value[gnt_idx];
      end
   end

endmodule

// ==== verilog/pw_trigger.sv ====
module pw_trigger
   import trig_cfg_pkg::*;
   import trig_event_pkg::*;
(
   input  logic         trigger_clk,
   input  logic         reset_i,
   trig_cfg_if.pulse_mp cfg,
   input  logic         match,
   output logic         trigger,
   output logic         evt_valid,
   output evt_value_t   evt_value
);

   // Counters
   trig_delay_t delay_cnt;
   trig_width_t width_cnt;
   // Phase flags
   logic        delay_running;
   logic        width_running;
   // Matches ignored while busy
   evt_value_t  drop_cnt;
   evt_value_t  drop_next;
   logic        busy;
   logic        pulse_end;

   assign busy = delay_running || width_running;

   // Last high cycle of the trigger
   // Compare with >= so a width of zero ends after one cycle
   assign pulse_end = width_running && (width_cnt >= cfg.width);

   // Drop count including a match on this edge, saturating
   assign drop_next = (busy && match && (drop_cnt != '1)) ?
                      drop_cnt + evt_value_t'(1) : drop_cnt;

   //////////////////////////////////////////////////////////////////////
   // Delay then width sequence
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge trigger_clk) begin
      if (reset_i) begin
         delay_cnt     <= '0;
         width_cnt     <= '0;
         delay_running <= 1'b0;
         width_running <= 1'b0;
         drop_cnt      <= '0;
         evt_valid     <= 1'b0;
      end else begin
         evt_valid <= 1'b0;
         if (!busy && match) begin
            // Start of delay phase
            delay_running <= 1'b1;
            delay_cnt     <= '0;
         end else if (delay_running) begin
            if (delay_cnt >= cfg.delay) begin
               // Delay done, trigger goes high
               delay_running <= 1'b0;
               width_running <= 1'b1;
               width_cnt     <= trig_width_t'(1);
            end else begin
               delay_cnt <= delay_cnt + trig_delay_t'(1);
            end
         end else if (width_running) begin
            if (pulse_end) begin
               width_running <= 1'b0;
               evt_valid     <= 1'b1;
            end else begin
               width_cnt <= width_cnt + trig_width_t'(1);
            end
         end

         // Count restarts once reported
         if (pulse_end) begin
            drop_cnt <= '0;
         end else begin
            drop_cnt <= drop_next;
         end
      end
   end

   // Pulse event value
   // Includes a match that lands on the falling edge itself
   always_ff @(posedge trigger_clk) begin
      if (pulse_end) begin
         evt_value <= drop_next;
      end
   end

   assign trigger = width_running;

endmodule

// ==== verilog/pattern_match.sv ====
module pattern_match
   import trig_cfg_pkg::*;
   import trig_event_pkg::*;
(
   input  logic         trigger_clk,
   input  logic         reset_i,
   trig_cfg_if.match_mp cfg,
   input  io_word_t     io_data,
   output logic         match,
   output logic         evt_valid,
   output evt_value_t   evt_value
);

   // Live compare result
   logic hit;
   // Compare result of the previous edge
   logic hit_q;
   // Fresh match on this edge
   logic hit_rise;

   //////////////////////////////////////////////////////////////////////
   // Masked compare
   //////////////////////////////////////////////////////////////////////

   // Only bits set in mask count
   // Arm folded in so disarming drops hit_q on the next edge
   assign hit = cfg.arm && (((io_data ^ cfg.pattern) & cfg.mask) == '0);

   // First cycle of a match only
   assign hit_rise = hit && !hit_q;

   //////////////////////////////////////////////////////////////////////
   // Edge detect and pulse
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge trigger_clk) begin
      if (reset_i) begin
         hit_q <= 1'b0;
         match <= 1'b0;
      end else begin
         hit_q <= hit;
         // One pulse per match, however long the byte is held
         match <= hit_rise;
      end
   end

   // Byte that caused the match
   // Loaded on the same edge that raises match
   always_ff @(posedge trigger_clk) begin
      if (hit_rise) begin
         evt_value <= evt_value_t'(io_data);
      end
   end

   // Match event rides on the match pulse itself
   assign evt_valid = match;

endmodule

// ==== verilog/trig_cfg_if.sv ====
interface trig_cfg_if
   import trig_cfg_pkg::*;
();

   // Matcher setup
   logic        arm;
   io_word_t    pattern;
   // Set bits take part in the compare
   io_word_t    mask;

   // Trigger generator setup
   trig_delay_t delay;
   trig_width_t width;

   // Pattern matcher view
   modport match_mp (
      input arm,
      input pattern,
      input mask
   );

   // Pulse generator view
   modport pulse_mp (
      input delay,
      input width
   );

endinterface

// ==== verilog/trig_event_pkg.sv ====
`include "trig_settings.svh"

package trig_event_pkg;

   // Wide enough for a zero-extended bus byte or a drop count
   localparam int EVT_VALUE_W = 17;

   // Source of a record
   // Encoding doubles as the arbiter slot index
   typedef enum logic {
      EVT_MATCH = 1'b0,
      EVT_PULSE = 1'b1
   } evt_kind_t;

   typedef logic [EVT_VALUE_W-1:0] evt_value_t;

   // 50-bit record on the event port
   typedef struct packed {
      evt_kind_t                kind;
      logic [`TRIG_STAMP_W-1:0] stamp;
      evt_value_t               value;
   } trig_event_t;

endpackage

// ==== verilog/trig_cfg_pkg.sv ====
`include "trig_settings.svh"

package trig_cfg_pkg;

   // One sample of the target I/O bus
   typedef logic [`TRIG_IO_W-1:0] io_word_t;

   // Cycles to wait between match and trigger
   typedef logic [`TRIG_DELAY_W-1:0] trig_delay_t;

   // Trigger high time in cycles
   // Zero gives the same pulse as one
   typedef logic [`TRIG_WIDTH_W-1:0] trig_width_t;

endpackage

// ==== verilog/trig_settings.svh ====
`ifndef TRIG_SETTINGS_SVH
`define TRIG_SETTINGS_SVH

// Target I/O bus width
`define TRIG_IO_W 8

// Delay counter width
// Covers about one million cycles between match and trigger
`define TRIG_DELAY_W 20

// Trigger pulse width counter
`define TRIG_WIDTH_W 17

// Free-running time stamp on each event record
`define TRIG_STAMP_W 32

// Credits on the outgoing event port
// Also the cap when credits come back
`define TRIG_EVT_CREDITS 4

`endif
